//--- common/axi_wr_pkg.sv
package axi_wr_pkg;

  // Bus widths shared by the AXI and AXI-Lite sides
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  // AXI-Lite writes allowed in flight
  localparam int TAG_DEPTH = 4;
  localparam int TAG_PTR_W = $clog2(TAG_DEPTH);
  localparam int TAG_CNT_W = $clog2(TAG_DEPTH + 1);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;

  // Beats minus one
  typedef logic [7:0] len_t;
  // log2 of bytes per beat
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR  = 2'd1;
  localparam burst_t BURST_WRAP  = 2'd2;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_BEATS
  } split_state_t;

endpackage

//--- axi_axil_wr/axi_burst_splitter.sv
module axi_burst_splitter
  import axi_wr_pkg::*;
(
  input  logic   clk,
  input  logic   i_reset,

  input  logic   i_s_axi_awvalid,
  input  addr_t  i_s_axi_awaddr,
  input  id_t    i_s_axi_awid,
  input  len_t   i_s_axi_awlen,
  input  size_t  i_s_axi_awsize,
  input  burst_t i_s_axi_awburst,
  output logic   o_s_axi_awready,

  output logic   o_split_valid,
  output addr_t  o_split_addr,
  output id_t    o_split_id,
  output logic   o_split_last,
  input  logic   i_split_ready
);

  split_state_t state;

  // Latched burst
  addr_t  addr_q;
  id_t    id_q;
  size_t  size_q;
  burst_t burst_q;
  addr_t  wrap_mask;
  len_t   beats_left;

  addr_t  step;
  addr_t  incr_addr;
  addr_t  next_addr;

  logic   aw_fire;
  logic   split_fire;

  assign o_s_axi_awready = (state == SPLIT_IDLE);
  assign o_split_valid   = (state == SPLIT_BEATS);
  assign o_split_addr    = addr_q;
  assign o_split_id      = id_q;
  assign o_split_last    = (beats_left == '0);

  assign aw_fire    = i_s_axi_awvalid && o_s_axi_awready;
  assign split_fire = o_split_valid && i_split_ready;

  // Address of the following beat
  always_comb begin
    step      = addr_t'(1) << size_q;
    incr_addr = addr_q + step;
    case (burst_q)
      BURST_FIXED: next_addr = addr_q;
      // Low bits wrap inside the aligned window while high bits stay
      BURST_WRAP:  next_addr = (addr_q & ~wrap_mask) | (incr_addr & wrap_mask);
      default:     next_addr = incr_addr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state      <= SPLIT_IDLE;
      beats_left <= '0;
    end else begin
      case (state)
        SPLIT_IDLE: begin
          if (aw_fire) begin
            state      <= SPLIT_BEATS;
            beats_left <= i_s_axi_awlen;
          end
        end
        SPLIT_BEATS: begin
          if (split_fire) begin
            if (o_split_last) begin
              state <= SPLIT_IDLE;
            end else begin
              beats_left <= beats_left - len_t'(1);
            end
          end
        end
        default: state <= SPLIT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      addr_q    <= i_s_axi_awaddr;
      id_q      <= i_s_axi_awid;
      size_q    <= i_s_axi_awsize;
      burst_q   <= i_s_axi_awburst;
      // Byte mask of a window of (len+1) beats
      wrap_mask <= ((addr_t'(i_s_axi_awlen) + addr_t'(1)) << i_s_axi_awsize) - addr_t'(1);
    end else if (split_fire) begin
      addr_q <= next_addr;
    end
  end

  // Stalled beat keeps its payload
  a_split_stable: assert property (
    @(posedge clk) disable iff (i_reset)
    o_split_valid && !i_split_ready |=>
      o_split_valid && $stable(o_split_addr) && $stable(o_split_id) && $stable(o_split_last)
  );

  // Next burst is taken only once the last beat has gone
  a_idle_after_last: assert property (
    @(posedge clk) disable iff (i_reset)
    split_fire && o_split_last |=> o_s_axi_awready && !o_split_valid
  );

endmodule

//--- axi_axil_wr/wr_tag_queue.sv
module wr_tag_queue
  import axi_wr_pkg::*;
(
  input  logic clk,
  input  logic i_reset,

  input  logic i_push,
  input  id_t  i_push_id,
  input  logic i_push_last,

  input  logic i_pop,
  output id_t  o_head_id,
  output logic o_head_last,

  output logic o_full,
  output logic o_empty
);

  id_t                  id_mem   [TAG_DEPTH];
  logic                 last_mem [TAG_DEPTH];

  logic [TAG_PTR_W-1:0] wr_ptr;
  logic [TAG_PTR_W-1:0] rd_ptr;
  logic [TAG_CNT_W-1:0] count;

  assign o_full      = (count == TAG_CNT_W'(TAG_DEPTH));
  assign o_empty     = (count == '0);
  assign o_head_id   = id_mem[rd_ptr];
  assign o_head_last = last_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (i_push) begin
      id_mem[wr_ptr]   <= i_push_id;
      last_mem[wr_ptr] <= i_push_last;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + TAG_PTR_W'(1);
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + TAG_PTR_W'(1);
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + TAG_CNT_W'(1);
        2'b01:   count <= count - TAG_CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (i_reset) !(i_push && o_full));
  a_no_underflow: assert property (@(posedge clk) disable iff (i_reset) !(i_pop && o_empty));

endmodule

//--- axi_axil_wr/axil_beat_writer.sv
module axil_beat_writer
  import axi_wr_pkg::*;
(
  input  logic  clk,
  input  logic  i_reset,

  // Split beats
  input  logic  i_split_valid,
  input  addr_t i_split_addr,
  input  id_t   i_split_id,
  input  logic  i_split_last,
  output logic  o_split_ready,

  // AXI W and B
  input  logic  i_s_axi_wvalid,
  input  data_t i_s_axi_wdata,
  input  strb_t i_s_axi_wstrb,
  input  logic  i_s_axi_wlast,
  output logic  o_s_axi_wready,
  output logic  o_s_axi_bvalid,
  output id_t   o_s_axi_bid,
  output resp_t o_s_axi_bresp,
  input  logic  i_s_axi_bready,

  // AXI-Lite AW, W and B
  output addr_t o_m_axil_awaddr,
  output logic  o_m_axil_awvalid,
  input  logic  i_m_axil_awready,
  output data_t o_m_axil_wdata,
  output strb_t o_m_axil_wstrb,
  output logic  o_m_axil_wvalid,
  input  logic  i_m_axil_wready,
  input  resp_t i_m_axil_bresp,
  input  logic  i_m_axil_bvalid,
  output logic  o_m_axil_bready
);

  logic  issuing;
  logic  can_take;
  logic  accept;

  logic  tag_full;
  logic  tag_empty;
  id_t   head_id;
  logic  head_last;
  logic  tag_pop;

  // First non-OKAY response of the current burst
  resp_t err_q;

  // One beat in issue at a time
  assign issuing  = o_m_axil_awvalid || o_m_axil_wvalid;
  assign can_take = !issuing && !tag_full;
  assign accept   = i_split_valid && i_s_axi_wvalid && can_take;

  assign o_split_ready  = can_take && i_s_axi_wvalid;
  assign o_s_axi_wready = can_take && i_split_valid;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_m_axil_awvalid <= 1'b0;
      o_m_axil_wvalid  <= 1'b0;
    end else if (accept) begin
      o_m_axil_awvalid <= 1'b1;
      o_m_axil_wvalid  <= 1'b1;
    end else begin
      // AW and W complete independently
      if (i_m_axil_awready) begin
        o_m_axil_awvalid <= 1'b0;
      end
      if (i_m_axil_wready) begin
        o_m_axil_wvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_m_axil_awaddr <= i_split_addr;
      o_m_axil_wdata  <= i_s_axi_wdata;
      o_m_axil_wstrb  <= i_s_axi_wstrb;
    end
  end

  wr_tag_queue u_tag_queue (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_push     (accept),
    .i_push_id  (i_split_id),
    .i_push_last(i_split_last),
    .i_pop      (tag_pop),
    .o_head_id  (head_id),
    .o_head_last(head_last),
    .o_full     (tag_full),
    .o_empty    (tag_empty)
  );

  // Last beat's response goes out as the burst's B
  assign o_m_axil_bready = !tag_empty && (head_last ? i_s_axi_bready : 1'b1);
  assign tag_pop         = i_m_axil_bvalid && o_m_axil_bready;

  assign o_s_axi_bvalid = i_m_axil_bvalid && !tag_empty && head_last;
  assign o_s_axi_bid    = head_id;
  assign o_s_axi_bresp  = (err_q != RESP_OKAY) ? err_q : i_m_axil_bresp;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      err_q <= RESP_OKAY;
    end else if (tag_pop) begin
      if (head_last) begin
        err_q <= RESP_OKAY;
      end else if (err_q == RESP_OKAY) begin
        err_q <= i_m_axil_bresp;
      end
    end
  end

  // W stream and split addresses stay in step
  a_wlast_match: assert property (
    @(posedge clk) disable iff (i_reset)
    accept |-> (i_s_axi_wlast == i_split_last)
  );

endmodule

//--- axi_axil_wr/axi_axil_wr_bridge.sv
module axi_axil_wr_bridge
  import axi_wr_pkg::*;
(
  input  logic   clk,
  input  logic   i_reset,

  // AXI subordinate
  input  logic   i_s_axi_awvalid,
  input  addr_t  i_s_axi_awaddr,
  input  id_t    i_s_axi_awid,
  input  len_t   i_s_axi_awlen,
  input  size_t  i_s_axi_awsize,
  input  burst_t i_s_axi_awburst,
  output logic   o_s_axi_awready,
  input  logic   i_s_axi_wvalid,
  input  data_t  i_s_axi_wdata,
  input  strb_t  i_s_axi_wstrb,
  input  logic   i_s_axi_wlast,
  output logic   o_s_axi_wready,
  output logic   o_s_axi_bvalid,
  output id_t    o_s_axi_bid,
  output resp_t  o_s_axi_bresp,
  input  logic   i_s_axi_bready,

  // AXI-Lite manager
  output addr_t  o_m_axil_awaddr,
  output logic   o_m_axil_awvalid,
  input  logic   i_m_axil_awready,
  output data_t  o_m_axil_wdata,
  output strb_t  o_m_axil_wstrb,
  output logic   o_m_axil_wvalid,
  input  logic   i_m_axil_wready,
  input  resp_t  i_m_axil_bresp,
  input  logic   i_m_axil_bvalid,
  output logic   o_m_axil_bready
);

  // Per-beat addresses from the splitter
  logic  split_valid;
  addr_t split_addr;
  id_t   split_id;
  logic  split_last;
  logic  split_ready;

  axi_burst_splitter u_splitter (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_s_axi_awvalid(i_s_axi_awvalid),
    .i_s_axi_awaddr (i_s_axi_awaddr),
    .i_s_axi_awid   (i_s_axi_awid),
    .i_s_axi_awlen  (i_s_axi_awlen),
    .i_s_axi_awsize (i_s_axi_awsize),
    .i_s_axi_awburst(i_s_axi_awburst),
    .o_s_axi_awready(o_s_axi_awready),
    .o_split_valid  (split_valid),
    .o_split_addr   (split_addr),
    .o_split_id     (split_id),
    .o_split_last   (split_last),
    .i_split_ready  (split_ready)
  );

  axil_beat_writer u_writer (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_split_valid   (split_valid),
    .i_split_addr    (split_addr),
    .i_split_id      (split_id),
    .i_split_last    (split_last),
    .o_split_ready   (split_ready),
    .i_s_axi_wvalid  (i_s_axi_wvalid),
    .i_s_axi_wdata   (i_s_axi_wdata),
    .i_s_axi_wstrb   (i_s_axi_wstrb),
    .i_s_axi_wlast   (i_s_axi_wlast),
    .o_s_axi_wready  (o_s_axi_wready),
    .o_s_axi_bvalid  (o_s_axi_bvalid),
    .o_s_axi_bid     (o_s_axi_bid),
    .o_s_axi_bresp   (o_s_axi_bresp),
    .i_s_axi_bready  (i_s_axi_bready),
    .o_m_axil_awaddr (o_m_axil_awaddr),
    .o_m_axil_awvalid(o_m_axil_awvalid),
    .i_m_axil_awready(i_m_axil_awready),
    .o_m_axil_wdata  (o_m_axil_wdata),
    .o_m_axil_wstrb  (o_m_axil_wstrb),
    .o_m_axil_wvalid (o_m_axil_wvalid),
    .i_m_axil_wready (i_m_axil_wready),
    .i_m_axil_bresp  (i_m_axil_bresp),
    .i_m_axil_bvalid (i_m_axil_bvalid),
    .o_m_axil_bready (o_m_axil_bready)
  );

endmodule

//--- tests/wr_checker.sv
module wr_checker
  import axi_wr_pkg::*;
(
  input  logic  clk,
  input  logic  i_reset,
  input  int    i_rows,

  input  addr_t i_m_axil_awaddr,
  input  logic  i_m_axil_awvalid,
  input  logic  i_m_axil_awready,
  input  data_t i_m_axil_wdata,
  input  strb_t i_m_axil_wstrb,
  input  logic  i_m_axil_wvalid,
  input  logic  i_m_axil_wready,
  input  logic  i_s_axi_bvalid,
  input  id_t   i_s_axi_bid,
  input  resp_t i_s_axi_bresp,
  input  logic  i_s_axi_bready,

  output int    o_errors,
  output int    o_bursts_done
);

  timeunit 1ns;
  timeprecision 1ps;

  int aw_row = 0;
  int aw_beat = 0;
  int w_row = 0;
  int w_beat = 0;

  // Address of beat k of table row r, by the AXI burst rules
  function automatic addr_t beat_addr(int r, int k);
    int unsigned a;
    int unsigned step;
    int unsigned win;
    int unsigned base;
    a    = tb_axi_axil_wr.row_addr[r];
    step = 1 << tb_axi_axil_wr.row_size[r];
    case (tb_axi_axil_wr.row_burst[r])
      BURST_FIXED: return addr_t'(a);
      BURST_WRAP: begin
        win  = (tb_axi_axil_wr.row_len[r] + 1) * step;
        base = (a / win) * win;
        return addr_t'(base + ((a - base + k * step) % win));
      end
      default: return addr_t'(a + k * step);
    endcase
  endfunction

  task automatic mismatch(string name, logic [31:0] exp_v, logic [31:0] act_v);
    $display("ERROR %0t %s expected %h got %h", $time, name, exp_v, act_v);
    o_errors++;
  endtask

  initial begin
    o_errors      = 0;
    o_bursts_done = 0;
  end

  always @(posedge clk) begin
    if (!i_reset && i_m_axil_awvalid && i_m_axil_awready) begin
      if (aw_row >= i_rows) begin
        $display("Unexpected AXI-Lite write address at %0t", $time);
        o_errors++;
      end else begin
        if (i_m_axil_awaddr !== beat_addr(aw_row, aw_beat))
          mismatch("o_m_axil_awaddr", beat_addr(aw_row, aw_beat), i_m_axil_awaddr);
        aw_beat++;
        if (aw_beat > tb_axi_axil_wr.row_len[aw_row]) begin
          aw_beat = 0;
          aw_row++;
        end
      end
    end
    if (!i_reset && i_m_axil_wvalid && i_m_axil_wready) begin
      if (w_row >= i_rows) begin
        $display("Unexpected AXI-Lite write data at %0t", $time);
        o_errors++;
      end else begin
        if (i_m_axil_wdata !== tb_axi_axil_wr.row_base[w_row] + w_beat)
          mismatch("o_m_axil_wdata", tb_axi_axil_wr.row_base[w_row] + w_beat, i_m_axil_wdata);
        if (i_m_axil_wstrb !== '1)
          mismatch("o_m_axil_wstrb", 32'(strb_t'('1)), 32'(i_m_axil_wstrb));
        w_beat++;
        if (w_beat > tb_axi_axil_wr.row_len[w_row]) begin
          w_beat = 0;
          w_row++;
        end
      end
    end
    if (!i_reset && i_s_axi_bvalid && i_s_axi_bready) begin
      if (o_bursts_done >= i_rows) begin
        $display("Extra AXI B response at %0t", $time);
        o_errors++;
      end else begin
        if (i_s_axi_bid !== tb_axi_axil_wr.row_id[o_bursts_done])
          mismatch("o_s_axi_bid", 32'(tb_axi_axil_wr.row_id[o_bursts_done]), 32'(i_s_axi_bid));
        if (i_s_axi_bresp !== (tb_axi_axil_wr.row_bad[o_bursts_done] ? RESP_SLVERR : RESP_OKAY))
          mismatch("o_s_axi_bresp",
                   tb_axi_axil_wr.row_bad[o_bursts_done] ? 32'(RESP_SLVERR) : 32'(RESP_OKAY),
                   32'(i_s_axi_bresp));
        o_bursts_done++;
      end
    end
  end

endmodule

//--- tests/tb_axi_axil_wr.sv
module tb_axi_axil_wr
  import axi_wr_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 7;
  localparam int MAX_CYCLES = 200 * NUM_ROWS + 100;

  // addr, id, len, size, burst kind, data base, bad-address flag
  addr_t  row_addr  [NUM_ROWS] = '{16'h1000, 16'h2004, 16'h3000, 16'h4010,
                                   16'h5008, 16'hEFF4, 16'h6000};
  id_t    row_id    [NUM_ROWS] = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7};
  len_t   row_len   [NUM_ROWS] = '{8'd0, 8'd3, 8'd7, 8'd2, 8'd3, 8'd3, 8'd1};
  size_t  row_size  [NUM_ROWS] = '{3'd2, 3'd2, 3'd2, 3'd2, 3'd2, 3'd2, 3'd1};
  burst_t row_burst [NUM_ROWS] = '{BURST_INCR, BURST_INCR, BURST_INCR, BURST_FIXED,
                                   BURST_WRAP, BURST_INCR, BURST_INCR};
  data_t  row_base  [NUM_ROWS] = '{32'h100, 32'h200, 32'h300, 32'h400,
                                   32'h500, 32'h600, 32'h700};
  logic   row_bad   [NUM_ROWS] = '{0, 0, 0, 0, 0, 1, 0};

  logic   clk;
  logic   i_reset;
  logic   i_s_axi_awvalid;
  addr_t  i_s_axi_awaddr;
  id_t    i_s_axi_awid;
  len_t   i_s_axi_awlen;
  size_t  i_s_axi_awsize;
  burst_t i_s_axi_awburst;
  logic   o_s_axi_awready;
  logic   i_s_axi_wvalid;
  data_t  i_s_axi_wdata;
  strb_t  i_s_axi_wstrb;
  logic   i_s_axi_wlast;
  logic   o_s_axi_wready;
  logic   o_s_axi_bvalid;
  id_t    o_s_axi_bid;
  resp_t  o_s_axi_bresp;
  logic   i_s_axi_bready;
  addr_t  o_m_axil_awaddr;
  logic   o_m_axil_awvalid;
  logic   i_m_axil_awready;
  data_t  o_m_axil_wdata;
  strb_t  o_m_axil_wstrb;
  logic   o_m_axil_wvalid;
  logic   i_m_axil_wready;
  resp_t  i_m_axil_bresp;
  logic   i_m_axil_bvalid;
  logic   o_m_axil_bready;

  int     seed = 44;
  int     cycles = 0;
  int     errors;
  int     bursts_done;
  addr_t  mem_aw_q [$];
  int     mem_w_count = 0;

  axi_axil_wr_bridge dut (.*);

  wr_checker chk (
    .clk(clk), .i_reset(i_reset), .i_rows(NUM_ROWS),
    .i_m_axil_awaddr(o_m_axil_awaddr), .i_m_axil_awvalid(o_m_axil_awvalid),
    .i_m_axil_awready(i_m_axil_awready), .i_m_axil_wdata(o_m_axil_wdata),
    .i_m_axil_wstrb(o_m_axil_wstrb), .i_m_axil_wvalid(o_m_axil_wvalid),
    .i_m_axil_wready(i_m_axil_wready), .i_s_axi_bvalid(o_s_axi_bvalid),
    .i_s_axi_bid(o_s_axi_bid), .i_s_axi_bresp(o_s_axi_bresp),
    .i_s_axi_bready(i_s_axi_bready), .o_errors(errors), .o_bursts_done(bursts_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    i_reset = 1'b1;
    i_s_axi_awvalid = 1'b0;
    i_s_axi_awaddr = '0;
    i_s_axi_awid = '0;
    i_s_axi_awlen = '0;
    i_s_axi_awsize = '0;
    i_s_axi_awburst = '0;
    i_s_axi_wvalid = 1'b0;
    i_s_axi_wdata = '0;
    i_s_axi_wstrb = '0;
    i_s_axi_wlast = 1'b0;
    i_s_axi_bready = 1'b0;
    i_m_axil_awready = 1'b0;
    i_m_axil_wready = 1'b0;
    i_m_axil_bresp = RESP_OKAY;
    i_m_axil_bvalid = 1'b0;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d bursts answered",
               cycles, bursts_done, NUM_ROWS);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Ready is sampled mid low phase and the transfer happens at the next rising edge
  task automatic wait_ready(ref logic ready);
    logic got;
    do begin
      #10;
      got = ready;
      @(negedge clk);
    end while (!got);
  endtask

  task automatic send_burst(int r);
    i_s_axi_awvalid = 1'b1;
    i_s_axi_awaddr  = row_addr[r];
    i_s_axi_awid    = row_id[r];
    i_s_axi_awlen   = row_len[r];
    i_s_axi_awsize  = row_size[r];
    i_s_axi_awburst = row_burst[r];
    wait_ready(o_s_axi_awready);
    i_s_axi_awvalid = 1'b0;
    for (int k = 0; k <= int'(row_len[r]); k++) begin
      repeat ($unsigned($random(seed)) % 3) @(negedge clk);
      i_s_axi_wvalid = 1'b1;
      i_s_axi_wdata  = row_base[r] + k;
      i_s_axi_wstrb  = '1;
      i_s_axi_wlast  = (k == int'(row_len[r]));
      wait_ready(o_s_axi_wready);
      i_s_axi_wvalid = 1'b0;
    end
  endtask

  // Random stalls on the AXI-Lite readies and on AXI B ready
  always @(negedge clk) begin
    if (!i_reset) begin
      i_m_axil_awready = ($unsigned($random(seed)) % 4) != 0;
      i_m_axil_wready  = ($unsigned($random(seed)) % 4) != 0;
      i_s_axi_bready   = ($unsigned($random(seed)) % 4) != 0;
    end
  end

  // Memory model bookkeeping of accepted addresses and data
  always @(posedge clk) begin
    if (o_m_axil_awvalid && i_m_axil_awready)
      mem_aw_q.push_back(o_m_axil_awaddr);
    if (o_m_axil_wvalid && i_m_axil_wready)
      mem_w_count++;
  end

  initial begin
    addr_t a;
    forever begin
      @(negedge clk);
      if (mem_aw_q.size() > 0 && mem_w_count > 0) begin
        a = mem_aw_q.pop_front();
        mem_w_count--;
        repeat ($unsigned($random(seed)) % 4) @(negedge clk);
        i_m_axil_bvalid = 1'b1;
        i_m_axil_bresp  = (a[15:12] == 4'hF) ? RESP_SLVERR : RESP_OKAY;
        wait_ready(o_m_axil_bready);
        i_m_axil_bvalid = 1'b0;
      end
    end
  end

  initial begin
    repeat (8) @(negedge clk);
    i_reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      send_burst(r);
    end
    while (bursts_done < NUM_ROWS) @(negedge clk);
    repeat (10) @(negedge clk);
    $display("Bursts answered %0d of %0d, errors %0d", bursts_done, NUM_ROWS, errors);
    if (errors == 0 && bursts_done == NUM_ROWS) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
common/axi_wr_pkg.sv
axi_axil_wr/axi_burst_splitter.sv
axi_axil_wr/wr_tag_queue.sv
axi_axil_wr/axil_beat_writer.sv
axi_axil_wr/axi_axil_wr_bridge.sv
tests/wr_checker.sv
tests/tb_axi_axil_wr.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI to AXI-Lite write bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_axi_axil_wr \
  -f sources.f

./obj_dir/Vtb_axi_axil_wr > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "Run ended without a result"
  exit 1
fi
exit 0
